/* bench/readout_stimulus.txt */
# mode, value (19-bit two's complement hex), expected bcd (hex), negative
# normal converts once, abort drops enable mid-conversion and then converts again
normal 00000 000000 0
normal 00001 000001 0
normal 00009 000009 0
normal 0000a 000010 0
normal 00063 000099 0
normal 003e8 001000 0
normal 0270f 009999 0
normal 1e240 123456 0
normal 3ffff 262143 0
normal 186a0 100000 0
normal 00800 002048 0
normal 0b26f 045679 0
normal 7ffff 000001 1
normal 7fff6 000010 1
normal 7ff9c 000100 1
abort 01234 004660 0
normal 0002a 000042 0
normal 61dc0 123456 1
normal 40001 262143 1
normal 40000 262144 1
abort 7fc18 001000 1
normal 7d8f1 009999 1
normal 03039 012345 0
normal 7cfc7 012345 1
normal 00100 000256 0
normal 50000 196608 1

/* bench/signed_readout_tb.sv */
`timescale 1ns/1ps

module signed_readout_tb;
    import readout_pkg::*;

    localparam int HOLD_CYCLES = 5;
    localparam int NUM_RANDOM  = 8;
    localparam int SLOT_CYCLES = 40 + HOLD_CYCLES + 5;  // budget per vector

    logic      clk;
    logic      reset;
    logic      enable;
    logic      start;
    bin_word_t value;
    bcd_word_t bcd;
    logic      negative;
    logic      ready;
    seg_bank_t segments;

    bin_word_t vec_value[$];
    bcd_word_t vec_bcd[$];
    logic      vec_neg[$];
    bit        vec_abort[$];
    int        watch_cycles = 0;
    integer    seed = 1;

    tb_clock_gen #(.PERIOD_NS(4)) u_clk (.clk(clk));

    signed_readout_top #(
        .HOLD_CYCLES(HOLD_CYCLES)
    ) u_dut (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .start    (start),
        .value    (value),
        .bcd      (bcd),
        .negative (negative),
        .ready    (ready),
        .segments (segments)
    );

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, actual,
                     expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // segments gfedcba, active high
    function automatic seg_t digit_pattern(input digit_t d);
        case (d)
            4'd0:    return 7'h3f;
            4'd1:    return 7'h06;
            4'd2:    return 7'h5b;
            4'd3:    return 7'h4f;
            4'd4:    return 7'h66;
            4'd5:    return 7'h6d;
            4'd6:    return 7'h7d;
            4'd7:    return 7'h07;
            4'd8:    return 7'h7f;
            4'd9:    return 7'h6f;
            default: return 7'h00;
        endcase
    endfunction

    function automatic seg_bank_t expected_segments(input bcd_word_t b, input logic neg);
        int        top;
        seg_bank_t s;
        top = 0;  // ones always lit
        for (int i = 0; i < 6; i++) begin
            if (b[4*i +: 4] != 4'd0) begin
                top = i;
            end
        end
        s = '0;
        for (int i = 0; i <= top; i++) begin
            s[7*i +: 7] = digit_pattern(b[4*i +: 4]);
        end
        s[42 +: 7] = neg ? 7'h40 : 7'h00;  // minus is segment g alone
        return s;
    endfunction

    function automatic bcd_word_t decimal_digits(input int mag);
        bcd_word_t b;
        int        rest;
        rest = mag;
        b    = '0;
        for (int i = 0; i < 6; i++) begin
            b[4*i +: 4] = 4'(rest % 10);
            rest        = rest / 10;
        end
        return b;
    endfunction

    task automatic run_conversion(input bin_word_t v, input bcd_word_t exp_bcd,
                                  input logic exp_neg, input bit intrude);
        int        edges;
        int        held;
        seg_bank_t exp_seg;
        exp_seg = expected_segments(exp_bcd, exp_neg);
        check_value(ready, 0, "ready before start");
        @(posedge clk);
        start <= 1'b1;
        value <= v;
        @(posedge clk);  // this edge takes the start
        start <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
            if (intrude && edges == 20) begin
                start <= 1'b1;  // mid-conversion, must be ignored
                value <= ~v;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
        end while (!ready && edges < 60);
        check_value(edges, 38, "edges from start to ready");
        held = 0;
        while (ready && held < 4 * HOLD_CYCLES) begin
            held++;
            check_value(bcd, exp_bcd, "bcd");
            check_value(negative, exp_neg, "negative");
            check_value(segments, exp_seg, "segments");
            @(posedge clk);
            if (intrude && held == 2) begin
                start <= 1'b1;  // during hold
                value <= v ^ 19'h1;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
        end
        check_value(held, HOLD_CYCLES, "ready high cycles");
        check_value(bcd, exp_bcd, "bcd after hold");
        check_value(segments, exp_seg, "segments after hold");
    endtask

    task automatic run_abort(input bin_word_t v, input bcd_word_t exp_bcd, input logic exp_neg);
        @(posedge clk);
        start <= 1'b1;
        value <= v;
        @(posedge clk);
        start <= 1'b0;
        repeat (12) @(posedge clk);
        enable <= 1'b0;
        repeat (2) @(posedge clk);
        enable <= 1'b1;
        repeat (40 + HOLD_CYCLES) begin
            @(negedge clk);
            check_value(ready, 0, "ready after abort");
        end
        run_conversion(v, exp_bcd, exp_neg, 1'b0);  // same value again, now to the end
    endtask

    initial begin : main_seq
        int             fd;
        int             fields;
        int             slots;
        int             mag;
        int             f_neg;
        logic [1023:0]  line_buf;
        logic [63:0]    mode_str;
        bin_word_t      f_value;
        bcd_word_t      f_bcd;
        bin_word_t      rv;

        reset  = 1'b1;
        enable = 1'b1;
        start  = 1'b0;
        value  = '0;

        fd = $fopen("bench/readout_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/readout_stimulus.txt");
            $display("Verification failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line_buf = '0;
            if ($fgets(line_buf, fd) > 0) begin
                fields = $sscanf(line_buf, "%s %h %h %d", mode_str, f_value, f_bcd, f_neg);
                if (fields == 4) begin
                    if (mode_str != "normal" && mode_str != "abort") begin
                        $display("Unknown mode in the stimulus file");
                        $display("Verification failed");
                        $fatal(1);
                    end
                    vec_abort.push_back(mode_str == "abort");
                    vec_value.push_back(f_value);
                    vec_bcd.push_back(f_bcd);
                    vec_neg.push_back(f_neg != 0);
                end
            end
        end
        $fclose(fd);

        slots = 2 + NUM_RANDOM;
        for (int i = 0; i < vec_abort.size(); i++) begin
            slots += vec_abort[i] ? 3 : 1;  // abort reruns its value
        end
        watch_cycles = slots * SLOT_CYCLES + 10;

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value(ready, 0, "ready after reset");
        check_value(bcd, 0, "bcd after reset");
        check_value(negative, 0, "negative after reset");
        check_value(segments, expected_segments('0, 1'b0), "segments after reset");

        for (int i = 0; i < vec_value.size(); i++) begin
            if (vec_abort[i]) begin
                run_abort(vec_value[i], vec_bcd[i], vec_neg[i]);
            end else begin
                run_conversion(vec_value[i], vec_bcd[i], vec_neg[i], i % 2 == 1);
            end
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rv  = bin_word_t'($random(seed));
            mag = rv[18] ? (1 << 19) - int'(rv) : int'(rv);
            run_conversion(rv, decimal_digits(mag), rv[18], n % 2 == 0);
        end

        $display("Verification passed");
        $finish;
    end

    initial begin : watchdog
        wait (watch_cycles > 0);
        repeat (watch_cycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", watch_cycles);
        $display("Verification failed");
        $fatal(1);
    end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;  // 50% duty

endmodule

/* files.f */
rtl/readout_pkg.sv
rtl/readout_ctrl.sv
rtl/magnitude_shifter.sv
rtl/bcd_digit_array.sv
rtl/hold_timer.sv
rtl/segment_encoder.sv
rtl/signed_readout_top.sv
bench/tb_clock_gen.sv
bench/signed_readout_tb.sv

/* rtl/bcd_digit_array.sv */
`timescale 1ns/1ps

module bcd_digit_array (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   shift,
    input  logic                   adjust,
    input  logic                   shift_bit,
    output readout_pkg::bcd_word_t bcd
);
    import readout_pkg::*;

    digit_t digit [NUM_DIGITS];  // digit[0] is ones
    logic   digits_ok;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                digit[i] <= '0;
            end
        end else if (load) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                digit[i] <= '0;
            end
        end else if (shift) begin
            digit[0] <= {digit[0][2:0], shift_bit};
            for (int i = 1; i < NUM_DIGITS; i++) begin
                digit[i] <= {digit[i][2:0], digit[i-1][3]};  // carry up the chain
            end
        end else if (adjust) begin
            for (int i = 0; i < NUM_DIGITS; i++) begin
                if (digit[i] > 4'd4) begin
                    digit[i] <= digit[i] + 4'd3;
                end
            end
        end
    end

    always_comb begin
        digits_ok = 1'b1;
        for (int i = 0; i < NUM_DIGITS; i++) begin
            bcd[4*i +: 4] = digit[i];
            if (digit[i] > 4'd9) begin
                digits_ok = 1'b0;
            end
        end
    end

    // adjusted digits reach 12 at most, the next shift brings them back to decimal
    a_bcd_valid: assert property (@(posedge clk) disable iff (reset)
        adjust ##1 shift |=> digits_ok);

endmodule

/* rtl/hold_timer.sv */
`timescale 1ns/1ps

module hold_timer #(
    parameter int HOLD_CYCLES = 5
) (
    input  logic clk,
    input  logic reset,
    input  logic hold_start,
    output logic hold_done
);
    localparam int               CNT_W = (HOLD_CYCLES > 1) ? $clog2(HOLD_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(HOLD_CYCLES - 1);

    logic [CNT_W-1:0] count;
    logic             running;

    assign hold_done = running && (count == LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            count   <= '0;
        end else if (hold_start) begin
            running <= 1'b1;  // restart even if busy
            count   <= '0;
        end else if (hold_done) begin
            running <= 1'b0;
            count   <= '0;
        end else if (running) begin
            count <= count + 1'b1;
        end
    end

endmodule

/* rtl/magnitude_shifter.sv */
`timescale 1ns/1ps

module magnitude_shifter (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   shift,
    input  readout_pkg::bin_word_t value,
    output logic                   shift_bit,
    output logic                   negative
);
    import readout_pkg::*;

    bin_word_t mag;  // unsigned, so 2**18 still fits

    assign shift_bit = mag[BIN_W-1];

    always_ff @(posedge clk) begin
        if (load) begin
            mag <= value[BIN_W-1] ? (~value + 1'b1) : value;
        end else if (shift) begin
            mag <= {mag[BIN_W-2:0], 1'b0};  // msb out first
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            negative <= 1'b0;
        end else if (load) begin
            negative <= value[BIN_W-1];
        end
    end

endmodule

/* rtl/readout_ctrl.sv */
`timescale 1ns/1ps

module readout_ctrl #(
    parameter int HOLD_CYCLES = 5
) (
    input  logic clk,
    input  logic reset,
    input  logic enable,
    input  logic start,
    input  logic hold_done,
    output logic load,
    output logic shift,
    output logic adjust,
    output logic hold_start,
    output logic ready
);
    import readout_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    logic [4:0]  step_cnt;   // shifts done so far
    logic        last_step;

    assign last_step = (step_cnt == 5'(SHIFT_STEPS - 1));

    // a start while ready is still high belongs to the hold
    assign load       = enable && start && !ready && (state == IDLE);
    assign shift      = enable && (state == SHIFT);
    assign adjust     = enable && (state == ADJUST);
    assign hold_start = shift && last_step;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    next_state = load ? SHIFT : IDLE;
            SHIFT:   next_state = last_step ? HOLD : ADJUST;  // no adjust after final shift
            ADJUST:  next_state = SHIFT;
            HOLD:    next_state = hold_done ? IDLE : HOLD;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else if (!enable) begin
            state <= IDLE;  // abort
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step_cnt <= '0;
        end else if (load) begin
            step_cnt <= '0;
        end else if (shift) begin
            step_cnt <= step_cnt + 5'd1;
        end
    end

    // lags HOLD by one edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready <= 1'b0;
        end else begin
            ready <= enable && (state == HOLD);
        end
    end

    // one strobe at a time, none held for two cycles
    a_strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        $onehot0({load, shift, adjust}) &&
        !(|({load, shift, adjust} & $past({load, shift, adjust}))));

    // only the hold_done exit leaves ready one cycle past HOLD
    a_ready_from_hold: assert property (@(posedge clk) disable iff (reset)
        ready |-> (state == HOLD) || $past(hold_done));

    // full hold window unless enable drops
    a_ready_length: assert property (@(posedge clk) disable iff (reset || !enable)
        $rose(ready) |-> ready [*HOLD_CYCLES] ##1 !ready);

endmodule

/* rtl/readout_pkg.sv */
package readout_pkg;

    localparam int BIN_W      = 19;
    localparam int NUM_DIGITS = 6;
    localparam int NUM_POS    = NUM_DIGITS + 1;  // digits plus sign
    localparam int SEG_W      = 7;

    // signed input and magnitude register
    typedef logic [BIN_W-1:0] bin_word_t;

    // ones digit in the low nibble
    typedef logic [4*NUM_DIGITS-1:0] bcd_word_t;

    typedef logic [3:0] digit_t;

    // bit 6 is segment g, bit 0 is segment a
    typedef logic [SEG_W-1:0] seg_t;

    // position 0 = ones digit, position 6 = sign
    typedef logic [SEG_W*NUM_POS-1:0] seg_bank_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        ADJUST,
        HOLD
    } ctrl_state_t;

    // one shift per magnitude bit
    localparam int SHIFT_STEPS = BIN_W;

    localparam seg_t SEG_BLANK = 7'b000_0000;
    localparam seg_t SEG_MINUS = 7'b100_0000;  // g only

endpackage

/* rtl/segment_encoder.sv */
`timescale 1ns/1ps

module segment_encoder (
    input  readout_pkg::bcd_word_t  bcd,
    input  logic                    negative,
    output readout_pkg::seg_bank_t  segments
);
    import readout_pkg::*;

    logic [NUM_DIGITS-1:0] lit;  // position shows its digit

    function automatic seg_t digit_to_seg(input digit_t d);
        case (d)
            4'd0:    return 7'b011_1111;
            4'd1:    return 7'b000_0110;
            4'd2:    return 7'b101_1011;
            4'd3:    return 7'b100_1111;
            4'd4:    return 7'b110_0110;
            4'd5:    return 7'b110_1101;
            4'd6:    return 7'b111_1101;
            4'd7:    return 7'b000_0111;
            4'd8:    return 7'b111_1111;
            4'd9:    return 7'b110_1111;
            default: return SEG_BLANK;  // not decimal
        endcase
    endfunction

    // lit from the highest nonzero digit downward
    always_comb begin
        lit[NUM_DIGITS-1] = (bcd[4*NUM_DIGITS-1 -: 4] != 4'd0);
        for (int i = NUM_DIGITS - 2; i >= 1; i--) begin
            lit[i] = lit[i+1] || (bcd[4*i +: 4] != 4'd0);
        end
        lit[0] = 1'b1;  // ones always shown
    end

    always_comb begin
        for (int i = 0; i < NUM_DIGITS; i++) begin
            segments[SEG_W*i +: SEG_W] = lit[i] ? digit_to_seg(bcd[4*i +: 4]) : SEG_BLANK;
        end
        segments[SEG_W*NUM_DIGITS +: SEG_W] = negative ? SEG_MINUS : SEG_BLANK;
    end

endmodule

/* rtl/signed_readout_top.sv */
`timescale 1ns/1ps

module signed_readout_top #(
    parameter int HOLD_CYCLES = 5
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   start,
    input  readout_pkg::bin_word_t value,
    output readout_pkg::bcd_word_t bcd,
    output logic                   negative,
    output logic                   ready,
    output readout_pkg::seg_bank_t segments
);

    logic load;
    logic shift;
    logic adjust;
    logic hold_start;
    logic hold_done;
    logic shift_bit;  // magnitude msb into the digit chain

    readout_ctrl #(
        .HOLD_CYCLES(HOLD_CYCLES)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .start      (start),
        .hold_done  (hold_done),
        .load       (load),
        .shift      (shift),
        .adjust     (adjust),
        .hold_start (hold_start),
        .ready      (ready)
    );

    magnitude_shifter u_shifter (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .shift     (shift),
        .value     (value),
        .shift_bit (shift_bit),
        .negative  (negative)
    );

    bcd_digit_array u_digits (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .shift     (shift),
        .adjust    (adjust),
        .shift_bit (shift_bit),
        .bcd       (bcd)
    );

    hold_timer #(
        .HOLD_CYCLES(HOLD_CYCLES)
    ) u_hold (
        .clk        (clk),
        .reset      (reset),
        .hold_start (hold_start),
        .hold_done  (hold_done)
    );

    segment_encoder u_segments (
        .bcd      (bcd),
        .negative (negative),
        .segments (segments)
    );

endmodule
